//--- dma_pkg.sv
/*
 * Shared widths, address map and types for the single-tile DMA controller.
 * table_ptr_width must stay at 7 or below, because the slot index sits in haddr[11:5].
 * table_entries must equal 2**table_ptr_width so that the round-robin pointer wraps.
 * mem_words must equal 2**mem_addr_width.
 */

package dma_pkg;

  //////////////////////////////////////////////////////////////////////
  // Bus and storage sizes
  //////////////////////////////////////////////////////////////////////

  localparam int addr_width = 32;
  localparam int data_width = 32;

  // Request table depth and its pointer
  localparam int table_entries   = 4;
  localparam int table_ptr_width = 2;

  // Scratch memory, word addressed
  localparam int mem_words      = 256;
  localparam int mem_addr_width = 8;

  // Only this tile exists, so any other id is an error
  localparam logic [7:0] local_tile = 8'd0;

  //////////////////////////////////////////////////////////////////////
  // Address map
  //////////////////////////////////////////////////////////////////////

  // Set selects the memory window, clear selects the table
  localparam int mem_window_bit = 12;

  // Byte offsets inside one 32-byte table slot
  localparam logic [4:0] off_laddr  = 5'h00;
  localparam logic [4:0] off_size   = 5'h04;
  localparam logic [4:0] off_rtile  = 5'h08;
  localparam logic [4:0] off_raddr  = 5'h0C;
  localparam logic [4:0] off_dir    = 5'h10;
  localparam logic [4:0] off_status = 5'h14;

  //////////////////////////////////////////////////////////////////////
  // Types
  //////////////////////////////////////////////////////////////////////

  // One descriptor, with each field cut to its stored width
  typedef struct packed {
    logic [7:0] laddr;
    logic [8:0] size;
    logic [7:0] rtile;
    logic [7:0] raddr;
    logic       dir;    // 0 copies laddr to raddr, 1 copies raddr to laddr
  } dma_req_t;

  typedef enum logic [2:0] {
    field_laddr,
    field_size,
    field_rtile,
    field_raddr,
    field_dir
  } dma_field_e;

  typedef struct packed {
    logic valid;
    logic done;
    logic error;
  } dma_status_t;

  // Scratch memory request from either side
  typedef struct packed {
    logic                      en;
    logic                      we;
    logic [mem_addr_width-1:0] addr;
    logic [data_width-1:0]     data;
  } mem_req_t;

endpackage

//--- dma_ahb_slave.sv
/*
 * AHB-Lite slave with the simplified handshake: hsel and hmastlock high accept an access.
 * Address and write data arrive together. There are no wait states and htrans is not decoded.
 * Read data shows on hrdata in the cycle after the access.
 */

`timescale 1ns/1ns

module dma_ahb_slave import dma_pkg::*; (
  input  logic                                  clk,
  input  logic                                  rst_n,

  // AHB-Lite side
  input  logic                                  hsel,
  input  logic [addr_width-1:0]                 haddr,
  input  logic [data_width-1:0]                 hwdata,
  input  logic                                  hwrite,
  input  logic                                  hmastlock,
  output logic [data_width-1:0]                 hrdata,
  output logic                                  hready,

  // Request table side
  output logic                                  field_wr,
  output logic [table_ptr_width-1:0]            field_pos,
  output dma_field_e                            field_sel,
  output logic [data_width-1:0]                 field_data,
  output logic                                  start,
  output logic [table_ptr_width-1:0]            start_pos,
  input  dma_status_t [table_entries-1:0]       status_all,

  // Scratch memory side
  output mem_req_t                              host_mem,
  input  logic [data_width-1:0]                 mem_rdata
);

  // Source of the read data in the following cycle
  typedef enum logic [1:0] {
    src_none,
    src_mem,
    src_status
  } rd_src_e;

  logic                       access;
  logic                       mem_sel;
  logic                       tbl_write;
  logic                       stat_read;
  logic [table_ptr_width-1:0] tbl_pos;
  logic [4:0]                 offset;
  rd_src_e                    rd_src_q;
  dma_status_t                stat_q;

  //////////////////////////////////////////////////////////////////////
  // Access decode
  //////////////////////////////////////////////////////////////////////

  assign access  = hsel & hmastlock;
  assign mem_sel = haddr[mem_window_bit];
  assign tbl_pos = haddr[table_ptr_width+4:5];
  assign offset  = haddr[4:0];

  assign tbl_write = access & ~mem_sel & hwrite;
  assign stat_read = access & ~mem_sel & ~hwrite & (offset == off_status);

  // No wait states
  assign hready = 1'b1;

  // Field writes for the five descriptor offsets
  assign field_pos  = tbl_pos;
  assign field_data = hwdata;

  always_comb begin
    field_wr  = 1'b0;
    field_sel = field_laddr;
    if (tbl_write) begin
      field_wr = 1'b1;
      case (offset)
        off_laddr: field_sel = field_laddr;
        off_size:  field_sel = field_size;
        off_rtile: field_sel = field_rtile;
        off_raddr: field_sel = field_raddr;
        off_dir:   field_sel = field_dir;
        default:   field_wr  = 1'b0;  // status offset or unmapped
      endcase
    end
  end

  // A write to the status word starts the slot
  assign start     = tbl_write & (offset == off_status);
  assign start_pos = tbl_pos;

  // Memory window, byte address to word address
  assign host_mem.en   = access & mem_sel;
  assign host_mem.we   = hwrite;
  assign host_mem.addr = haddr[mem_addr_width+1:2];
  assign host_mem.data = hwdata;

  //////////////////////////////////////////////////////////////////////
  // Read response
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rd_src_q <= src_none;
      stat_q   <= '0;
    end else begin
      if (access && !hwrite && mem_sel) begin
        rd_src_q <= src_mem;
      end else if (stat_read) begin
        rd_src_q <= src_status;
      end else begin
        rd_src_q <= src_none;  // descriptor reads and idle cycles give 0
      end
      if (stat_read) begin
        stat_q <= status_all[tbl_pos];
      end
    end
  end

  // Memory data is already registered inside the scratch memory
  always_comb begin
    case (rd_src_q)
      src_mem:    hrdata = mem_rdata;
      src_status: hrdata = {{(data_width-2){1'b0}}, stat_q.error, stat_q.done};
      default:    hrdata = '0;
    endcase
  end

endmodule

//--- dma_request_table.sv
/*
 * Descriptor table with valid, done and error bits for each slot.
 * Every strobe takes effect at the next clock edge. All state clears on reset.
 * If a start and a finish hit the same slot together, the start wins.
 */

`timescale 1ns/1ns

module dma_request_table import dma_pkg::*; (
  input  logic                                  clk,
  input  logic                                  rst_n,

  // Host field writes and starts
  input  logic                                  field_wr,
  input  logic [table_ptr_width-1:0]            field_pos,
  input  dma_field_e                            field_sel,
  input  logic [data_width-1:0]                 field_data,
  input  logic                                  start,
  input  logic [table_ptr_width-1:0]            start_pos,

  // Completion from the engine
  input  logic                                  finish,
  input  logic [table_ptr_width-1:0]            finish_pos,
  input  logic                                  finish_err,

  output dma_req_t    [table_entries-1:0]       req_all,
  output dma_status_t [table_entries-1:0]       status_all
);

  //////////////////////////////////////////////////////////////////////
  // Descriptor storage
  //////////////////////////////////////////////////////////////////////

  // Upper bus bits are dropped, each field keeps only its own width
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      req_all <= '0;
    end else if (field_wr) begin
      case (field_sel)
        field_laddr: req_all[field_pos].laddr <= field_data[7:0];
        field_size:  req_all[field_pos].size  <= field_data[8:0];
        field_rtile: req_all[field_pos].rtile <= field_data[7:0];
        field_raddr: req_all[field_pos].raddr <= field_data[7:0];
        field_dir:   req_all[field_pos].dir   <= field_data[0];
        default:     req_all[field_pos].dir   <= req_all[field_pos].dir;
      endcase
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Slot status
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      status_all <= '0;
    end else begin
      // Completion retires the slot and reports the result
      if (finish) begin
        status_all[finish_pos].valid <= 1'b0;
        status_all[finish_pos].done  <= 1'b1;
        status_all[finish_pos].error <= finish_err;
      end
      // Start comes second so it overrides a same-slot finish
      if (start) begin
        status_all[start_pos].valid <= 1'b1;
        status_all[start_pos].done  <= 1'b0;
        status_all[start_pos].error <= 1'b0;
      end
    end
  end

endmodule

//--- dma_transfer_engine.sv
/*
 * Copies words inside the scratch memory for one started slot at a time, in round-robin order.
 * Each word costs a read cycle and a write cycle. The engine stalls while grant_eng is low.
 * Addresses wrap at the memory size. A remote tile or a zero size goes straight to finish.
 */

`timescale 1ns/1ns

module dma_transfer_engine import dma_pkg::*; (
  input  logic                                  clk,
  input  logic                                  rst_n,

  input  dma_req_t    [table_entries-1:0]       req_all,
  input  dma_status_t [table_entries-1:0]       status_all,

  // Scratch memory port, held while not granted
  output mem_req_t                              eng_mem,
  input  logic                                  grant_eng,
  input  logic [data_width-1:0]                 mem_rdata,

  output logic                                  finish,
  output logic [table_ptr_width-1:0]            finish_pos,
  output logic                                  finish_err
);

  typedef enum logic [1:0] {
    st_idle,
    st_read,
    st_write,
    st_finish
  } eng_state_e;

  eng_state_e                 state_q;
  logic [table_ptr_width-1:0] last_q;      // slot served most recently
  logic [mem_addr_width-1:0]  src_q;
  logic [mem_addr_width-1:0]  dst_q;
  logic [8:0]                 count_q;     // words left
  logic                       err_q;
  logic                       fresh_q;     // mem_rdata holds our word this cycle
  logic [data_width-1:0]      data_q;
  logic [data_width-1:0]      wdata;
  logic                       pick_found;
  logic [table_ptr_width-1:0] pick_pos;

  //////////////////////////////////////////////////////////////////////
  // Round-robin pick
  //////////////////////////////////////////////////////////////////////

  // Scan starting one past the last served slot, the pointer wraps by width
  always_comb begin
    logic [table_ptr_width-1:0] idx;
    pick_found = 1'b0;
    pick_pos   = '0;
    for (int i = 1; i <= table_entries; i++) begin
      idx = last_q + table_ptr_width'(i);
      if (!pick_found && status_all[idx].valid && !status_all[idx].done) begin
        pick_found = 1'b1;
        pick_pos   = idx;
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Copy FSM
  //////////////////////////////////////////////////////////////////////

  // Only the first write cycle sees the fresh word, a stalled write reuses the copy
  assign wdata = fresh_q ? mem_rdata : data_q;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q <= st_idle;
      last_q  <= '0;
      src_q   <= '0;
      dst_q   <= '0;
      count_q <= '0;
      err_q   <= 1'b0;
      fresh_q <= 1'b0;
      data_q  <= '0;
    end else begin
      case (state_q)
        st_idle: begin
          if (pick_found) begin
            last_q  <= pick_pos;
            count_q <= req_all[pick_pos].size;
            err_q   <= (req_all[pick_pos].rtile != local_tile);
            // Direction picks which address is the source
            if (req_all[pick_pos].dir) begin
              src_q <= req_all[pick_pos].raddr;
              dst_q <= req_all[pick_pos].laddr;
            end else begin
              src_q <= req_all[pick_pos].laddr;
              dst_q <= req_all[pick_pos].raddr;
            end
            if (req_all[pick_pos].rtile != local_tile || req_all[pick_pos].size == '0) begin
              state_q <= st_finish;
            end else begin
              state_q <= st_read;
            end
          end
        end
        st_read: begin
          if (grant_eng) begin
            fresh_q <= 1'b1;
            state_q <= st_write;
          end
        end
        st_write: begin
          data_q  <= wdata;
          fresh_q <= 1'b0;
          if (grant_eng) begin
            src_q   <= src_q + 1'b1;
            dst_q   <= dst_q + 1'b1;
            count_q <= count_q - 1'b1;
            state_q <= (count_q == 9'd1) ? st_finish : st_read;
          end
        end
        default: begin
          state_q <= st_idle;   // finish lasts one cycle
        end
      endcase
    end
  end

  // Requests follow the state, so nothing is driven out of reset
  assign eng_mem.en   = (state_q == st_read) || (state_q == st_write);
  assign eng_mem.we   = (state_q == st_write);
  assign eng_mem.addr = (state_q == st_write) ? dst_q : src_q;
  assign eng_mem.data = wdata;

  assign finish     = (state_q == st_finish);
  assign finish_pos = last_q;
  assign finish_err = err_q;

endmodule

//--- dma_scratch_mem.sv
/*
 * Single-port word memory shared by the host and the engine, with the host first.
 * The read port is registered, so data follows one cycle after an accepted read.
 * Both sides share mem_rdata and take it only in the cycle after their own read.
 */

`timescale 1ns/1ns

module dma_scratch_mem import dma_pkg::*; (
  input  logic                  clk,
  input  logic                  rst_n,
  input  mem_req_t              host_mem,
  input  mem_req_t              eng_mem,
  output logic [data_width-1:0] mem_rdata,
  output logic                  grant_eng
);

  logic [data_width-1:0] mem [mem_words];
  mem_req_t              sel;

  // Host wins, the engine holds its request until granted
  assign grant_eng = ~host_mem.en;
  assign sel       = host_mem.en ? host_mem : eng_mem;

  //////////////////////////////////////////////////////////////////////
  // Storage and read port
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (sel.en && sel.we) begin
      mem[sel.addr] <= sel.data;
    end
  end

  // Writes leave the read register alone
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      mem_rdata <= '0;
    end else if (sel.en && !sel.we) begin
      mem_rdata <= mem[sel.addr];
    end
  end

endmodule

//--- dma_top.sv
/*
 * Single-tile DMA controller behind an AHB-Lite slave port.
 * Table slots sit in the low window, the scratch memory where haddr[12] is set.
 * hready is always high.
 */

`timescale 1ns/1ns

module dma_top import dma_pkg::*; (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  hsel,
  input  logic [addr_width-1:0] haddr,
  input  logic [data_width-1:0] hwdata,
  input  logic                  hwrite,
  input  logic                  hmastlock,
  output logic [data_width-1:0] hrdata,
  output logic                  hready
);

  // Slave to table
  logic                                field_wr;
  logic [table_ptr_width-1:0]          field_pos;
  dma_field_e                          field_sel;
  logic [data_width-1:0]               field_data;
  logic                                start;
  logic [table_ptr_width-1:0]          start_pos;

  // Table to engine and back
  dma_req_t    [table_entries-1:0]     req_all;
  dma_status_t [table_entries-1:0]     status_all;
  logic                                finish;
  logic [table_ptr_width-1:0]          finish_pos;
  logic                                finish_err;

  // Memory ports
  mem_req_t                            host_mem;
  mem_req_t                            eng_mem;
  logic [data_width-1:0]               mem_rdata;
  logic                                grant_eng;

  dma_ahb_slave u_slave (
    .clk        (clk),
    .rst_n      (rst_n),
    .hsel       (hsel),
    .haddr      (haddr),
    .hwdata     (hwdata),
    .hwrite     (hwrite),
    .hmastlock  (hmastlock),
    .hrdata     (hrdata),
    .hready     (hready),
    .field_wr   (field_wr),
    .field_pos  (field_pos),
    .field_sel  (field_sel),
    .field_data (field_data),
    .start      (start),
    .start_pos  (start_pos),
    .status_all (status_all),
    .host_mem   (host_mem),
    .mem_rdata  (mem_rdata)
  );

  dma_request_table u_table (
    .clk        (clk),
    .rst_n      (rst_n),
    .field_wr   (field_wr),
    .field_pos  (field_pos),
    .field_sel  (field_sel),
    .field_data (field_data),
    .start      (start),
    .start_pos  (start_pos),
    .finish     (finish),
    .finish_pos (finish_pos),
    .finish_err (finish_err),
    .req_all    (req_all),
    .status_all (status_all)
  );

  dma_transfer_engine u_engine (
    .clk        (clk),
    .rst_n      (rst_n),
    .req_all    (req_all),
    .status_all (status_all),
    .eng_mem    (eng_mem),
    .grant_eng  (grant_eng),
    .mem_rdata  (mem_rdata),
    .finish     (finish),
    .finish_pos (finish_pos),
    .finish_err (finish_err)
  );

  dma_scratch_mem u_mem (
    .clk        (clk),
    .rst_n      (rst_n),
    .host_mem   (host_mem),
    .eng_mem    (eng_mem),
    .mem_rdata  (mem_rdata),
    .grant_eng  (grant_eng)
  );

endmodule

//--- tb_dma.sv
/*
 * Directed testbench for the single-tile DMA controller.
 * Inputs change on the falling clock edge and hrdata is sampled there too.
 * A local model of the scratch memory gives the expected words.
 * The run stops after max_cycles clock cycles in any case.
 */

`timescale 1ns/1ns

module tb_dma import dma_pkg::*; ();

  localparam int max_cycles = 4000;
  localparam int poll_limit = 150;

  logic                  clk;
  logic                  rst_n;
  logic                  hsel;
  logic [addr_width-1:0] haddr;
  logic [data_width-1:0] hwdata;
  logic                  hwrite;
  logic                  hmastlock;
  logic [data_width-1:0] hrdata;
  logic                  hready;

  // Expected scratch memory contents
  logic [data_width-1:0] model [mem_words];

  integer seed = 32'h6592;
  int     check_errors = 0;
  int     poll_timeouts = 0;
  int     cycles = 0;

  dma_top u_dut (
    .clk       (clk),
    .rst_n     (rst_n),
    .hsel      (hsel),
    .haddr     (haddr),
    .hwdata    (hwdata),
    .hwrite    (hwrite),
    .hmastlock (hmastlock),
    .hrdata    (hrdata),
    .hready    (hready)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  // Hard stop for a hung run
  initial begin
    while (cycles < max_cycles) begin
      @(posedge clk);
      cycles++;
    end
    $display("Simulation ran past %0d cycles without finishing", max_cycles);
    $display("Test failed");
    $finish;
  end

  //////////////////////////////////////////////////////////////////////
  // Address helpers and checks
  //////////////////////////////////////////////////////////////////////

  // Memory window, byte address of a word
  function automatic logic [31:0] mem_addr(input logic [7:0] word);
    return (32'd1 << mem_window_bit) | {22'd0, word, 2'b00};
  endfunction

  // Table window, 32 bytes per slot
  function automatic logic [31:0] slot_addr(input int pos, input logic [4:0] off);
    return (32'(pos) << 5) | {27'd0, off};
  endfunction

  task automatic check_value(input logic [31:0] got, input logic [31:0] exp, input string what);
    assert (got === exp) else begin
      check_errors++;
      $display("CHECK FAILED at %0t: %s, got %h expected %h", $time, what, got, exp);
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // Bus tasks, each starts and ends on a falling edge
  //////////////////////////////////////////////////////////////////////

  task automatic bus_write(input logic [31:0] addr, input logic [31:0] data);
    hsel      = 1'b1;
    hmastlock = 1'b1;
    hwrite    = 1'b1;
    haddr     = addr;
    hwdata    = data;
    @(negedge clk);
    hsel      = 1'b0;
    hmastlock = 1'b0;
    hwrite    = 1'b0;
  endtask

  // Data is on hrdata one cycle after the strobe
  task automatic bus_read(input logic [31:0] addr, output logic [31:0] data);
    hsel      = 1'b1;
    hmastlock = 1'b1;
    hwrite    = 1'b0;
    haddr     = addr;
    @(negedge clk);
    hsel      = 1'b0;
    hmastlock = 1'b0;
    data      = hrdata;
    // No wait states, so hready stays high
    check_value({31'd0, hready}, 32'd1, "hready during read");
  endtask

  task automatic program_request(input int pos, input logic [7:0] laddr, input logic [8:0] size,
                                 input logic [7:0] rtile, input logic [7:0] raddr,
                                 input logic dir);
    bus_write(slot_addr(pos, off_laddr), {24'd0, laddr});
    bus_write(slot_addr(pos, off_size), {23'd0, size});
    bus_write(slot_addr(pos, off_rtile), {24'd0, rtile});
    bus_write(slot_addr(pos, off_raddr), {24'd0, raddr});
    bus_write(slot_addr(pos, off_dir), {31'd0, dir});
  endtask

  // Status reads until done shows, bounded by poll_limit
  task automatic poll_done(input int pos, output logic [31:0] status);
    int polls;
    polls  = 0;
    status = '0;
    while (status[0] !== 1'b1 && polls < poll_limit) begin
      bus_read(slot_addr(pos, off_status), status);
      polls++;
    end
    if (status[0] !== 1'b1) begin
      poll_timeouts++;
      $display("Slot %0d never reported done after %0d status reads", pos, poll_limit);
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // Model and compound steps
  //////////////////////////////////////////////////////////////////////

  // Word by word in ascending order, wrapping at the memory size
  task automatic model_copy(input logic [7:0] src, input logic [7:0] dst, input int count);
    for (int i = 0; i < count; i++) begin
      model[8'(dst + 8'(i))] = model[8'(src + 8'(i))];
    end
  endtask

  task automatic check_range(input logic [7:0] first, input int count);
    logic [31:0] data;
    logic [7:0]  a;
    for (int i = 0; i < count; i++) begin
      a = 8'(first + 8'(i));
      bus_read(mem_addr(a), data);
      check_value(data, model[a], $sformatf("memory word %h", a));
    end
  endtask

  // Program, start, wait and check one slot, then update the model
  task automatic run_request(input int pos, input logic [7:0] laddr, input logic [8:0] size,
                             input logic [7:0] rtile, input logic [7:0] raddr, input logic dir);
    logic [31:0] status;
    logic [31:0] exp_status;
    exp_status = (rtile != local_tile) ? 32'h3 : 32'h1;
    program_request(pos, laddr, size, rtile, raddr, dir);
    bus_write(slot_addr(pos, off_status), 32'd0);
    poll_done(pos, status);
    check_value(status, exp_status, $sformatf("status of slot %0d", pos));
    if (rtile == local_tile) begin
      if (dir) begin
        model_copy(raddr, laddr, int'(size));
      end else begin
        model_copy(laddr, raddr, int'(size));
      end
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // Tests
  //////////////////////////////////////////////////////////////////////

  task automatic test_reset_and_memory();
    logic [31:0] data;
    check_value(hrdata, 32'd0, "hrdata after reset");
    for (int p = 0; p < table_entries; p++) begin
      bus_read(slot_addr(p, off_status), data);
      check_value(data, 32'd0, $sformatf("status of slot %0d after reset", p));
    end
    bus_read(slot_addr(1, off_size), data);
    check_value(data, 32'd0, "descriptor field read");
    // Fill every word so the model is known everywhere
    for (int a = 0; a < mem_words; a++) begin
      model[a] = $random(seed);
      bus_write(mem_addr(8'(a)), model[a]);
    end
    check_range(8'h00, mem_words);
  endtask

  task automatic test_copies();
    // Direction 0, plus one word either side of the destination
    run_request(0, 8'h10, 9'd8, local_tile, 8'h30, 1'b0);
    check_range(8'h2F, 10);
    // Direction 1 with the source wrapping past the top
    run_request(1, 8'h80, 9'd10, local_tile, 8'hFA, 1'b1);
    check_range(8'h7F, 12);
    // Destination overlaps the source
    run_request(2, 8'h50, 9'd8, local_tile, 8'h53, 1'b0);
    check_range(8'h4F, 14);
  endtask

  task automatic test_error_paths();
    run_request(3, 8'h60, 9'd4, 8'd5, 8'h70, 1'b0);
    check_range(8'h60, 4);
    check_range(8'h70, 4);
    run_request(0, 8'h61, 9'd0, local_tile, 8'h71, 1'b0);
    check_range(8'h71, 1);
  endtask

  task automatic test_queue();
    logic [31:0] data;
    logic [31:0] status;
    program_request(0, 8'h00, 9'd8, local_tile, 8'hA0, 1'b0);
    program_request(1, 8'hB0, 9'd8, local_tile, 8'h08, 1'b1);
    program_request(2, 8'h10, 9'd8, local_tile, 8'hC0, 1'b0);
    program_request(3, 8'h18, 9'd8, local_tile, 8'hD0, 1'b0);
    for (int p = 0; p < table_entries; p++) begin
      bus_write(slot_addr(p, off_status), 32'd0);
    end
    // Host reads stall the engine, none of these words is a destination
    for (int a = 8'h20; a < 8'h30; a++) begin
      bus_read(mem_addr(8'(a)), data);
      check_value(data, model[a], $sformatf("host read %h during transfers", a));
    end
    for (int p = 0; p < table_entries; p++) begin
      poll_done(p, status);
      check_value(status, 32'h1, $sformatf("queued slot %0d status", p));
    end
    model_copy(8'h00, 8'hA0, 8);
    model_copy(8'h08, 8'hB0, 8);
    model_copy(8'h10, 8'hC0, 8);
    model_copy(8'h18, 8'hD0, 8);
    check_range(8'h9F, 58);
  endtask

  task automatic test_restart();
    logic [31:0] status;
    bus_read(slot_addr(0, off_status), status);
    check_value(status, 32'h1, "slot 0 done before restart");
    program_request(0, 8'hE0, 9'd4, local_tile, 8'hE8, 1'b0);
    bus_write(slot_addr(0, off_status), 32'd0);
    // Done must drop right after the start
    bus_read(slot_addr(0, off_status), status);
    check_value(status, 32'h0, "slot 0 status right after restart");
    poll_done(0, status);
    check_value(status, 32'h1, "slot 0 status after restart");
    model_copy(8'hE0, 8'hE8, 4);
    check_range(8'hE7, 6);
  endtask

  //////////////////////////////////////////////////////////////////////
  // Main sequence
  //////////////////////////////////////////////////////////////////////

  initial begin
    rst_n     = 1'b0;
    hsel      = 1'b0;
    haddr     = '0;
    hwdata    = '0;
    hwrite    = 1'b0;
    hmastlock = 1'b0;
    repeat (3) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
    @(negedge clk);
    test_reset_and_memory();
    test_copies();
    test_error_paths();
    test_queue();
    test_restart();
    $display("Summary: %0d check errors, %0d poll timeouts", check_errors, poll_timeouts);
    if (check_errors == 0 && poll_timeouts == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

//--- vlog.f
dma_pkg.sv
dma_ahb_slave.sv
dma_request_table.sv
dma_transfer_engine.sv
dma_scratch_mem.sv
dma_top.sv
tb_dma.sv

//--- Makefile
# Verilator build and run of the DMA testbench

SRCS := $(wildcard *.sv)

obj_dir/Vtb_dma: $(SRCS) vlog.f
	verilator --binary --timing -Wno-fatal --top-module tb_dma -f vlog.f

.PHONY: run clean

# Fails unless the pass message shows up in the output
run: obj_dir/Vtb_dma
	@out="$$(./obj_dir/Vtb_dma)"; \
	echo "$$out"; \
	echo "$$out" | grep -q "Test completed successfully"

clean:
	rm -rf obj_dir
